// ==== source/backend_pkg.sv ====
//////////////////////////////////////////////////
// Backend shared definitions
// Widths, buffer sizes, vector types, run status
//////////////////////////////////////////////////

package backend_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Result data width
    localparam int xlen = 32;

    // Reorder buffer depth, power of two keeps the wrap cheap
    localparam int rob_size = 8;

    // Physical destination tag width
    localparam int phys_tag_width = 6;

    // Index into the buffer
    localparam int rob_idx_width = $clog2(rob_size);

    // Occupancy needs one more state than the index (0..rob_size)
    localparam int rob_count_width = $clog2(rob_size + 1);

    // Retired instruction counter, wraps
    localparam int retire_count_width = 16;

    //////////////////////////////////////////////////
    // Common data bus sources
    //////////////////////////////////////////////////

    // Execution sources feeding the bus
    localparam int cdb_source_count = 3;
    localparam int src_sel_width    = $clog2(cdb_source_count);

    // Priority slots, lower slot wins
    localparam int src_mul  = 0;
    localparam int src_load = 1;
    localparam int src_alu  = 2;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [xlen-1:0]               data_t;
    typedef logic [phys_tag_width-1:0]     phys_tag_t;
    typedef logic [rob_idx_width-1:0]      rob_idx_t;
    typedef logic [rob_count_width-1:0]    rob_count_t;
    typedef logic [retire_count_width-1:0] retire_count_t;

    // Bus winner slot
    typedef logic [src_sel_width-1:0]      src_sel_t;

    // Machine status, halted is sticky until reset
    typedef enum logic {
        status_running,
        status_halted
    } exec_status_t;

endpackage

// ==== source/cdb_arbiter.sv ====
//////////////////////////////////////////////////
// Common data bus arbiter
// Fixed priority mul > load > alu, winner registered
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cdb_arbiter
    import backend_pkg::*;
(
    input  logic     clock,
    input  logic     reset,

    // Execution sources
    input  logic     alu_valid,
    input  logic     mul_valid,
    input  logic     load_valid,
    input  rob_idx_t alu_rob_idx,
    input  rob_idx_t mul_rob_idx,
    input  rob_idx_t load_rob_idx,
    input  data_t    alu_data,
    input  data_t    mul_data,
    input  data_t    load_data,

    // Losers hold their result while stalled
    output logic     alu_stall,
    output logic     mul_stall,
    output logic     load_stall,

    // Broadcast
    output logic     cdb_valid,
    output rob_idx_t cdb_rob_idx,
    output data_t    cdb_data
);

    //////////////////////////////////////////////////
    // Gather sources in priority order
    //////////////////////////////////////////////////

    logic [cdb_source_count-1:0] src_valid;
    logic [cdb_source_count-1:0] src_stall;
    rob_idx_t                    src_idx  [cdb_source_count];
    data_t                       src_data [cdb_source_count];

    // Winning slot this cycle
    src_sel_t                    win_sel;

    always_comb begin
        src_valid[src_mul]  = mul_valid;
        src_valid[src_load] = load_valid;
        src_valid[src_alu]  = alu_valid;

        src_idx[src_mul]    = mul_rob_idx;
        src_idx[src_load]   = load_rob_idx;
        src_idx[src_alu]    = alu_rob_idx;

        src_data[src_mul]   = mul_data;
        src_data[src_load]  = load_data;
        src_data[src_alu]   = alu_data;
    end

    //////////////////////////////////////////////////
    // Priority pick and stalls
    //////////////////////////////////////////////////

    always_comb begin
        logic higher_valid;
        higher_valid = 1'b0;
        win_sel      = '0;
        // Walk from top priority down
        for (int i = 0; i < cdb_source_count; i++) begin
            src_stall[i] = src_valid[i] & higher_valid;
            if (src_valid[i] && !higher_valid) begin
                win_sel = src_sel_t'(i);
            end
            higher_valid = higher_valid | src_valid[i];
        end
    end

    // Mul never sees a higher source, its stall stays low
    assign mul_stall  = src_stall[src_mul];
    assign load_stall = src_stall[src_load];
    assign alu_stall  = src_stall[src_alu];

    //////////////////////////////////////////////////
    // Bus register
    //////////////////////////////////////////////////

    // One pulse per accepted result
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= |src_valid;
        end
    end

    // Payload only moves when something wins
    always_ff @(posedge clock) begin
        if (|src_valid) begin
            cdb_rob_idx <= src_idx[win_sel];
            cdb_data    <= src_data[win_sel];
        end
    end

endmodule

// ==== source/reorder_buffer.sv ====
//////////////////////////////////////////////////
// Reorder buffer
// In-order allocation, completion from the bus
//////////////////////////////////////////////////

`timescale 1ns/1ps

module reorder_buffer
    import backend_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // Dispatch side
    input  logic      dispatch_valid,
    input  logic      dispatch_halt,
    input  phys_tag_t dispatch_tag,
    output rob_idx_t  dispatch_rob_idx,
    output logic      rob_full,

    // Completion from the common data bus
    input  logic      cdb_valid,
    input  rob_idx_t  cdb_rob_idx,
    input  data_t     cdb_data,

    // Retire side
    input  logic      retire_en,
    output logic      head_valid,
    output logic      head_complete,
    output logic      head_halt,
    output phys_tag_t head_tag,
    output data_t     head_data
);

    //////////////////////////////////////////////////
    // Entry storage
    //////////////////////////////////////////////////

    // Per-entry status bits
    logic [rob_size-1:0] entry_valid;
    logic [rob_size-1:0] entry_complete;
    logic [rob_size-1:0] entry_halt;

    // Per-entry payload
    phys_tag_t           entry_tag  [rob_size];
    data_t               entry_data [rob_size];

    // Pointers and occupancy
    rob_idx_t            head;
    rob_idx_t            tail;
    rob_count_t          count;

    // Accepted dispatch this cycle
    logic                alloc;

    // Step a pointer with wrap at rob_size
    function automatic rob_idx_t next_idx(input rob_idx_t idx);
        if (idx == rob_idx_t'(rob_size - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Status outputs
    //////////////////////////////////////////////////

    assign rob_full         = (count == rob_count_t'(rob_size));
    assign alloc            = dispatch_valid & ~rob_full;

    // New instruction lands at the tail
    assign dispatch_rob_idx = tail;

    // Head view for the retire unit
    assign head_valid       = entry_valid[head];
    assign head_complete    = entry_complete[head];
    assign head_halt        = entry_halt[head];
    assign head_tag         = entry_tag[head];
    assign head_data        = entry_data[head];

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            entry_valid    <= '0;
            entry_complete <= '0;
            entry_halt     <= '0;
        end else begin
            // Release the head
            if (retire_en) begin
                entry_valid[head] <= 1'b0;
                head              <= next_idx(head);
            end

            // Result broadcast marks its entry done
            if (cdb_valid) begin
                entry_complete[cdb_rob_idx] <= 1'b1;
            end

            // Allocation last, a fresh entry starts clean
            // Halt has no result so it is done at once
            if (alloc) begin
                entry_valid[tail]    <= 1'b1;
                entry_complete[tail] <= dispatch_halt;
                entry_halt[tail]     <= dispatch_halt;
                tail                 <= next_idx(tail);
            end

            // Occupancy, both at once leaves it unchanged
            case ({alloc, retire_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Payload
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_tag[tail] <= dispatch_tag;
        end
        // Result value written with its completion
        if (cdb_valid) begin
            entry_data[cdb_rob_idx] <= cdb_data;
        end
    end

endmodule

// ==== source/rob_retire.sv ====
//////////////////////////////////////////////////
// Retire unit
// In-order release, sticky halt, retire count
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rob_retire
    import backend_pkg::*;
(
    input  logic          clock,
    input  logic          reset,

    // Head of the reorder buffer
    input  logic          head_valid,
    input  logic          head_complete,
    input  logic          head_halt,

    // Retire strobe back to the buffer
    output logic          retire_en,

    // Run status and count
    output exec_status_t  status,
    output retire_count_t retired_count
);

    //////////////////////////////////////////////////
    // Retire decision
    //////////////////////////////////////////////////

    // Only a finished head retires, and never once halted
    assign retire_en = head_valid
                     & head_complete
                     & (status == status_running);

    //////////////////////////////////////////////////
    // Halt status
    //////////////////////////////////////////////////

    // Halt takes effect at the edge that retires it
    always_ff @(posedge clock) begin
        if (reset) begin
            status <= status_running;
        end else if (retire_en && head_halt) begin
            status <= status_halted;
        end
    end

    //////////////////////////////////////////////////
    // Retired instruction counter
    //////////////////////////////////////////////////

    // Halt retirement counts too, wraps at 16 bits
    always_ff @(posedge clock) begin
        if (reset) begin
            retired_count <= '0;
        end else if (retire_en) begin
            retired_count <= retired_count + 1'b1;
        end
    end

endmodule

// ==== source/backend_top.sv ====
//////////////////////////////////////////////////
// Backend top
// Bus arbiter, reorder buffer and retire unit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module backend_top
    import backend_pkg::*;
(
    input  logic          clock,
    input  logic          reset,

    // Execution sources
    input  logic          alu_valid,
    input  logic          mul_valid,
    input  logic          load_valid,
    input  rob_idx_t      alu_rob_idx,
    input  rob_idx_t      mul_rob_idx,
    input  rob_idx_t      load_rob_idx,
    input  data_t         alu_data,
    input  data_t         mul_data,
    input  data_t         load_data,
    output logic          alu_stall,
    output logic          mul_stall,
    output logic          load_stall,

    // Dispatch
    input  logic          dispatch_valid,
    input  phys_tag_t     dispatch_tag,
    input  logic          dispatch_halt,
    output rob_idx_t      dispatch_rob_idx,
    output logic          rob_full,

    // Common data bus
    output logic          cdb_valid,
    output rob_idx_t      cdb_rob_idx,
    output data_t         cdb_data,

    // Retire
    output logic          retire_valid,
    output phys_tag_t     retire_tag,
    output data_t         retire_data,
    output exec_status_t  status,
    output retire_count_t retired_count
);

    // Head of the buffer and the retire strobe
    logic      head_valid;
    logic      head_complete;
    logic      head_halt;
    phys_tag_t head_tag;
    data_t     head_data;
    logic      retire_en;

    // Retire report is the head in the retiring cycle
    assign retire_valid = retire_en;
    assign retire_tag   = head_tag;
    assign retire_data  = head_data;

    //////////////////////////////////////////////////
    // Completion
    //////////////////////////////////////////////////

    cdb_arbiter u_cdb_arbiter (
        .clock        (clock),
        .reset        (reset),
        .alu_valid    (alu_valid),
        .mul_valid    (mul_valid),
        .load_valid   (load_valid),
        .alu_rob_idx  (alu_rob_idx),
        .mul_rob_idx  (mul_rob_idx),
        .load_rob_idx (load_rob_idx),
        .alu_data     (alu_data),
        .mul_data     (mul_data),
        .load_data    (load_data),
        .alu_stall    (alu_stall),
        .mul_stall    (mul_stall),
        .load_stall   (load_stall),
        .cdb_valid    (cdb_valid),
        .cdb_rob_idx  (cdb_rob_idx),
        .cdb_data     (cdb_data)
    );

    //////////////////////////////////////////////////
    // Reorder buffer
    //////////////////////////////////////////////////

    reorder_buffer u_reorder_buffer (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_halt    (dispatch_halt),
        .dispatch_tag     (dispatch_tag),
        .dispatch_rob_idx (dispatch_rob_idx),
        .rob_full         (rob_full),
        .cdb_valid        (cdb_valid),
        .cdb_rob_idx      (cdb_rob_idx),
        .cdb_data         (cdb_data),
        .retire_en        (retire_en),
        .head_valid       (head_valid),
        .head_complete    (head_complete),
        .head_halt        (head_halt),
        .head_tag         (head_tag),
        .head_data        (head_data)
    );

    //////////////////////////////////////////////////
    // Retire
    //////////////////////////////////////////////////

    rob_retire u_rob_retire (
        .clock         (clock),
        .reset         (reset),
        .head_valid    (head_valid),
        .head_complete (head_complete),
        .head_halt     (head_halt),
        .retire_en     (retire_en),
        .status        (status),
        .retired_count (retired_count)
    );

endmodule

// ==== testbench/backend_props.sv ====
//////////////////////////////////////////////////
// Reorder buffer properties
//////////////////////////////////////////////////

`timescale 1ns/1ps

module backend_props
    import backend_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input logic     rob_full,
    input logic     head_valid,
    input logic     dispatch_valid,
    input rob_idx_t tail
);

    // A full buffer always offers a live head to retire
    assert property (@(posedge clock) disable iff (reset)
        rob_full |-> head_valid)
        else $error("buffer full while the head entry is empty");

    // Dispatch into a full buffer leaves the tail alone
    assert property (@(posedge clock) disable iff (reset)
        (dispatch_valid && rob_full) |=> (tail == $past(tail)))
        else $error("dispatch accepted while the buffer was full");

endmodule

bind reorder_buffer backend_props u_props (
    .clock          (clock),
    .reset          (reset),
    .rob_full       (rob_full),
    .head_valid     (head_valid),
    .dispatch_valid (dispatch_valid),
    .tail           (tail)
);

// ==== testbench/backend_checker.sv ====
//////////////////////////////////////////////////
// Backend checker
// Reference model of bus, buffer and retire order
//////////////////////////////////////////////////

`timescale 1ns/1ps

module backend_checker
    import backend_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          alu_valid,
    input  logic          mul_valid,
    input  logic          load_valid,
    input  rob_idx_t      alu_rob_idx,
    input  rob_idx_t      mul_rob_idx,
    input  rob_idx_t      load_rob_idx,
    input  data_t         alu_data,
    input  data_t         mul_data,
    input  data_t         load_data,
    input  logic          alu_stall,
    input  logic          mul_stall,
    input  logic          load_stall,
    input  logic          dispatch_valid,
    input  phys_tag_t     dispatch_tag,
    input  logic          dispatch_halt,
    input  rob_idx_t      dispatch_rob_idx,
    input  logic          rob_full,
    input  logic          cdb_valid,
    input  rob_idx_t      cdb_rob_idx,
    input  data_t         cdb_data,
    input  logic          retire_valid,
    input  phys_tag_t     retire_tag,
    input  data_t         retire_data,
    input  exec_status_t  status,
    input  retire_count_t retired_count,
    // Test bookkeeping from the stimulus side
    input  logic          test_done,
    input  int            test_id,
    input  logic [1:0]    exp_kind,
    input  logic          exp_value,
    output int            error_count,
    output int            check_count
);

    // Model of the buffer
    phys_tag_t           m_tag  [rob_size];
    data_t               m_data [rob_size];
    logic [rob_size-1:0] m_complete;
    logic [rob_size-1:0] m_halt;
    rob_idx_t            m_head;
    rob_idx_t            m_tail;
    int                  m_count;
    logic                m_halted;
    int                  ret_pulses;
    int                  test_errors_base;
    logic                reset_edge;

    // Bus result expected next cycle
    logic                pend_valid;
    rob_idx_t            pend_idx;
    data_t               pend_data;

    initial begin
        error_count      = 0;
        check_count      = 0;
        test_errors_base = 0;
        reset_edge       = 1'b0;
    end

    task automatic expect_true(input logic ok, input string msg);
        check_count++;
        if (!ok) begin
            error_count++;
            $display("FAIL %0t: %s", $time, msg);
        end
    endtask

    // Reset seen at the last rising edge
    always @(posedge clock) begin
        reset_edge <= reset;
    end

    //////////////////////////////////////////////////
    // Compare on the falling edge, all stable
    //////////////////////////////////////////////////

    always @(negedge clock) begin
        logic     exp_ret;
        logic     full_now;
        logic     old_valid;
        rob_idx_t old_idx;
        data_t    old_data;
        if (reset) begin
            if (reset_edge) begin
                expect_true(!cdb_valid && !retire_valid, "bus or retire active in reset");
                expect_true(!alu_stall && !mul_stall && !load_stall, "stall high in reset");
                expect_true(!rob_full, "rob_full high in reset");
                expect_true(status == status_running, "status not running in reset");
                expect_true(retired_count == '0, "retired_count not zero in reset");
            end
            m_complete = '0;
            m_halt     = '0;
            m_head     = '0;
            m_tail     = '0;
            m_count    = 0;
            m_halted   = 1'b0;
            ret_pulses = 0;
            pend_valid = 1'b0;
        end else begin
            // Stalls follow priority mul, load, alu
            expect_true(!mul_stall, "mul stalled");
            expect_true(load_stall == (load_valid && mul_valid), "load_stall wrong");
            expect_true(alu_stall == (alu_valid && (mul_valid || load_valid)),
                        "alu_stall wrong");

            // Bus carries last cycle's winner
            old_valid = pend_valid;
            old_idx   = pend_idx;
            old_data  = pend_data;
            expect_true(cdb_valid == old_valid, "cdb_valid wrong");
            if (old_valid && cdb_valid) begin
                expect_true(cdb_rob_idx == old_idx && cdb_data == old_data,
                            $sformatf("cdb carries idx %0d data %h, expected %0d %h",
                                      cdb_rob_idx, cdb_data, old_idx, old_data));
            end
            pend_valid = mul_valid || load_valid || alu_valid;
            if (mul_valid) begin
                pend_idx  = mul_rob_idx;
                pend_data = mul_data;
            end else if (load_valid) begin
                pend_idx  = load_rob_idx;
                pend_data = load_data;
            end else begin
                pend_idx  = alu_rob_idx;
                pend_data = alu_data;
            end

            // Buffer view
            full_now = (m_count == rob_size);
            expect_true(rob_full == full_now, "rob_full wrong");
            expect_true(dispatch_rob_idx == m_tail, "dispatch_rob_idx wrong");

            // In-order retire of the oldest entry
            exp_ret = !m_halted && (m_count > 0) && m_complete[m_head];
            expect_true(retire_valid == exp_ret,
                        $sformatf("retire_valid %0b, expected %0b", retire_valid, exp_ret));
            if (retire_valid && exp_ret) begin
                expect_true(retire_tag == m_tag[m_head],
                            $sformatf("retire_tag %0d, expected %0d",
                                      retire_tag, m_tag[m_head]));
                if (!m_halt[m_head]) begin
                    expect_true(retire_data == m_data[m_head],
                                $sformatf("retire_data %h, expected %h",
                                          retire_data, m_data[m_head]));
                end
            end
            expect_true(retired_count == retire_count_t'(ret_pulses), "retired_count wrong");
            expect_true((status == status_halted) == m_halted, "status wrong");

            // Row expectations
            if (exp_kind == 2'd1) begin
                expect_true(rob_full == exp_value, "rob_full differs from table");
            end else if (exp_kind == 2'd2) begin
                expect_true((status == status_halted) == exp_value,
                            "status differs from table");
            end

            // Advance the model past this edge
            if (retire_valid) begin
                ret_pulses++;
            end
            if (exp_ret) begin
                if (m_halt[m_head]) begin
                    m_halted = 1'b1;
                end
                m_head  = rob_idx_t'((m_head + 1) % rob_size);
                m_count--;
            end
            if (old_valid) begin
                m_complete[old_idx] = 1'b1;
                m_data[old_idx]     = old_data;
            end
            if (dispatch_valid && !full_now) begin
                m_tag[m_tail]      = dispatch_tag;
                m_halt[m_tail]     = dispatch_halt;
                m_complete[m_tail] = dispatch_halt;
                m_tail             = rob_idx_t'((m_tail + 1) % rob_size);
                m_count++;
            end
        end

        if (test_done) begin
            $display("test %0d done: %0d errors", test_id, error_count - test_errors_base);
            test_errors_base = error_count;
        end
    end

endmodule

// ==== testbench/backend_tb.sv ====
//////////////////////////////////////////////////
// Backend testbench
// Table driven front end and execution units
//////////////////////////////////////////////////

`timescale 1ns/1ps

module backend_tb
    import backend_pkg::*;
;

    localparam int          period = 40;
    localparam logic [31:0] seed   = 32'h6a2e25dc;

    // Row kinds
    localparam int op_idle     = 0;
    localparam int op_dispatch = 1;
    localparam int op_result   = 2;

    logic clock = 1'b0;
    logic reset;

    logic          alu_valid;
    logic          mul_valid;
    logic          load_valid;
    rob_idx_t      alu_rob_idx;
    rob_idx_t      mul_rob_idx;
    rob_idx_t      load_rob_idx;
    data_t         alu_data;
    data_t         mul_data;
    data_t         load_data;
    logic          alu_stall;
    logic          mul_stall;
    logic          load_stall;
    logic          dispatch_valid;
    logic          dispatch_halt;
    phys_tag_t     dispatch_tag;
    rob_idx_t      dispatch_rob_idx;
    logic          rob_full;
    logic          cdb_valid;
    rob_idx_t      cdb_rob_idx;
    data_t         cdb_data;
    logic          retire_valid;
    phys_tag_t     retire_tag;
    data_t         retire_data;
    exec_status_t  status;
    retire_count_t retired_count;

    logic          test_done;
    int            test_id;
    logic [1:0]    exp_kind;
    logic          exp_value;
    int            error_count;
    int            check_count;
    logic          table_ready;
    logic [31:0]   lfsr_state;

    // Stimulus table with one queue entry per row
    int         row_test [$];
    int         row_op   [$];
    int         row_arg  [$];
    logic       row_halt [$];
    logic [2:0] row_mask [$];
    int         row_mi   [$];
    int         row_li   [$];
    int         row_ai   [$];
    int         row_exp  [$];

    always #(period / 2) clock = ~clock;

    backend_top u_dut (.*);

    backend_checker u_checker (.*);

    //////////////////////////////////////////////////
    // Random data
    //////////////////////////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output data_t w);
        for (int i = 0; i < xlen; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[xlen-2:0], lfsr_state[0]};
        end
    endtask

    // Mask bit 2 is mul, bit 1 load, bit 0 alu
    // An exp of -1 skips the table check
    task automatic add_row(input int t, input int op, input int arg, input logic halt,
                           input logic [2:0] mask, input int mi, input int li,
                           input int ai, input int exp);
        row_test.push_back(t);
        row_op.push_back(op);
        row_arg.push_back(arg);
        row_halt.push_back(halt);
        row_mask.push_back(mask);
        row_mi.push_back(mi);
        row_li.push_back(li);
        row_ai.push_back(ai);
        row_exp.push_back(exp);
    endtask

    task automatic build_table();
        // Out of order completion
        for (int i = 1; i <= 3; i++) begin
            add_row(1, op_dispatch, i, 1'b0, 3'b000, 0, 0, 0, 0);
        end
        add_row(1, op_result, 0, 1'b0, 3'b001, 0, 0, 2, -1);
        add_row(1, op_result, 0, 1'b0, 3'b100, 1, 0, 0, -1);
        add_row(1, op_result, 0, 1'b0, 3'b010, 0, 0, 0, -1);
        add_row(1, op_idle, 4, 1'b0, 3'b000, 0, 0, 0, -1);
        // All three sources at once
        for (int i = 4; i <= 6; i++) begin
            add_row(2, op_dispatch, i, 1'b0, 3'b000, 0, 0, 0, 0);
        end
        add_row(2, op_result, 0, 1'b0, 3'b111, 5, 4, 3, -1);
        add_row(2, op_idle, 5, 1'b0, 3'b000, 0, 0, 0, -1);
        // Fill the buffer, try one more, then free the head
        for (int i = 10; i <= 17; i++) begin
            add_row(3, op_dispatch, i, 1'b0, 3'b000, 0, 0, 0, 0);
        end
        add_row(3, op_dispatch, 18, 1'b0, 3'b000, 0, 0, 0, 1);
        add_row(3, op_result, 0, 1'b0, 3'b001, 0, 0, 6, -1);
        add_row(3, op_idle, 3, 1'b0, 3'b000, 0, 0, 0, -1);
        add_row(3, op_dispatch, 19, 1'b0, 3'b000, 0, 0, 0, 0);
        add_row(3, op_result, 0, 1'b0, 3'b111, 7, 0, 1, -1);
        add_row(3, op_result, 0, 1'b0, 3'b111, 2, 3, 4, -1);
        add_row(3, op_result, 0, 1'b0, 3'b110, 5, 6, 0, -1);
        add_row(3, op_idle, 10, 1'b0, 3'b000, 0, 0, 0, -1);
        // Halt followed by a finished entry that must stay
        add_row(4, op_dispatch, 20, 1'b1, 3'b000, 0, 0, 0, 0);
        add_row(4, op_dispatch, 21, 1'b0, 3'b000, 0, 0, 0, 0);
        add_row(4, op_result, 0, 1'b0, 3'b001, 0, 0, 0, -1);
        add_row(4, op_idle, 5, 1'b0, 3'b000, 0, 0, 0, 1);
    endtask

    //////////////////////////////////////////////////
    // Row drivers enter and leave 2 ns after an edge
    //////////////////////////////////////////////////

    task automatic issue_dispatch(input int r);
        dispatch_valid = 1'b1;
        dispatch_tag   = phys_tag_t'(row_arg[r]);
        dispatch_halt  = row_halt[r];
        exp_kind       = 2'd1;
        exp_value      = (row_exp[r] == 1);
        @(posedge clock);
        #2;
        dispatch_valid = 1'b0;
        dispatch_halt  = 1'b0;
        exp_kind       = 2'd0;
    endtask

    task automatic send_results(input int r);
        logic [2:0] pending;
        logic [2:0] accepted;
        pending = row_mask[r];
        mul_valid    = pending[2];
        load_valid   = pending[1];
        alu_valid    = pending[0];
        mul_rob_idx  = rob_idx_t'(row_mi[r]);
        load_rob_idx = rob_idx_t'(row_li[r]);
        alu_rob_idx  = rob_idx_t'(row_ai[r]);
        draw_word(mul_data);
        draw_word(load_data);
        draw_word(alu_data);
        // Stalled sources hold until taken
        while (pending != 3'b000) begin
            @(negedge clock);
            accepted = pending & ~{mul_stall, load_stall, alu_stall};
            @(posedge clock);
            #2;
            pending = pending & ~accepted;
            mul_valid  = pending[2];
            load_valid = pending[1];
            alu_valid  = pending[0];
        end
    endtask

    task automatic idle_cycles(input int r);
        for (int i = 0; i < row_arg[r]; i++) begin
            // Table value checked in the last cycle
            if (i == row_arg[r] - 1 && row_exp[r] >= 0) begin
                exp_kind  = 2'd2;
                exp_value = (row_exp[r] == 1);
            end
            @(posedge clock);
            #2;
        end
        exp_kind = 2'd0;
    endtask

    task automatic finish_test(input int t);
        test_id   = t;
        test_done = 1'b1;
        @(posedge clock);
        #2;
        test_done = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////

    initial begin
        wait (table_ready);
        #((row_op.size() * 10 + 100) * period);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        reset          = 1'b1;
        alu_valid      = 1'b0;
        mul_valid      = 1'b0;
        load_valid     = 1'b0;
        alu_rob_idx    = '0;
        mul_rob_idx    = '0;
        load_rob_idx   = '0;
        alu_data       = '0;
        mul_data       = '0;
        load_data      = '0;
        dispatch_valid = 1'b0;
        dispatch_tag   = '0;
        dispatch_halt  = 1'b0;
        test_done      = 1'b0;
        test_id        = 0;
        exp_kind       = 2'd0;
        exp_value      = 1'b0;
        lfsr_state     = seed;
        table_ready    = 1'b0;
        build_table();
        table_ready    = 1'b1;

        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int r = 0; r < row_op.size(); r++) begin
            case (row_op[r])
                op_dispatch: issue_dispatch(r);
                op_result:   send_results(r);
                default:     idle_cycles(r);
            endcase
            if (r == row_op.size() - 1 || row_test[r + 1] != row_test[r]) begin
                finish_test(row_test[r]);
            end
        end

        // Second reset returns every output to idle
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #2;
        finish_test(5);
        reset = 1'b0;
        repeat (2) @(posedge clock);

        $display("total: 5 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/backend_pkg.sv
source/cdb_arbiter.sv
source/reorder_buffer.sv
source/rob_retire.sv
source/backend_top.sv
testbench/backend_props.sv
testbench/backend_checker.sv
testbench/backend_tb.sv

// ==== Makefile ====
TOP := backend_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -sv -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -sv -f src.f --top-module $(TOP) -o backend_sim
	./obj_dir/backend_sim | tee /dev/stderr | grep -q "No errors"

clean:
	rm -rf obj_dir
